// File: source/gbCorePkg.sv
`default_nettype none

package gbCorePkg;

  localparam int dataWidth    = 8;
  localparam int addrWidth    = 16;
  localparam int flowIdxWidth = 6;

  localparam logic [addrWidth-1:0] resetPc = 16'h0000;

  // Opcodes not decoded by field
  localparam logic [dataWidth-1:0] ldA16 = 8'hea;
  localparam logic [dataWidth-1:0] jpNn  = 8'hc3;
  localparam logic [dataWidth-1:0] jpNz  = 8'hc2;
  localparam logic [dataWidth-1:0] jpZ   = 8'hca;
  localparam logic [dataWidth-1:0] jpNc  = 8'hd2;
  localparam logic [dataWidth-1:0] jpC   = 8'hda;

  localparam logic [dataWidth-1:0] opIncBase = 8'h04;  // 00rrr100
  localparam logic [dataWidth-1:0] opDecBase = 8'h05;  // 00rrr101

  // ALU group operation field
  localparam logic [2:0] aluAdd = 3'b000;
  localparam logic [2:0] aluSub = 3'b010;
  localparam logic [2:0] aluAnd = 3'b100;
  localparam logic [2:0] aluXor = 3'b101;
  localparam logic [2:0] aluOr  = 3'b110;

  // ------------------------------------------------------------------------
  // Codes 0 to 7 follow the opcode register field
  typedef enum logic [3:0] {
    selB    = 4'd0,
    selC    = 4'd1,
    selD    = 4'd2,
    selE    = 4'd3,
    selH    = 4'd4,
    selL    = 4'd5,
    selMem  = 4'd6,  // (HL) slot, lands on A
    selA    = 4'd7,
    selX16L = 4'd8,
    selX16H = 4'd9,
    selX16  = 4'd10,
    selPc   = 4'd11,
    selNone = 4'd12
  } regSelT;

  typedef enum logic [2:0] {
    cmdNop, cmdSetAddr, cmdStoreRead, cmdMemWrite, cmdExec, cmdSetPc
  } uopCmdT;

  typedef enum logic [2:0] {
    eofNever, eofAlways, eofIfC, eofIfNc, eofIfZ, eofIfNz
  } eofCondT;

  typedef struct packed {
    uopCmdT  cmd;
    eofCondT eofCond;
    logic    incPc;
    regSelT  operand;
  } uopT;

  // Bits 5:3 are a register for loads and INC/DEC, an operation for ALU
  typedef union packed {
    struct packed {
      logic [1:0] group;
      logic [2:0] dst;
      logic [2:0] src;
    } ldView;
    struct packed {
      logic [1:0] group;
      logic [2:0] aluOp;
      logic [2:0] src;
    } aluView;
  } opcodeT;

  typedef struct packed {
    logic z;
    logic c;
  } flagsT;

  localparam flagsT resetFlags = '{z: 1'b1, c: 1'b1};

  typedef struct packed {
    logic [dataWidth-1:0] b;
    logic [dataWidth-1:0] c;
    logic [dataWidth-1:0] d;
    logic [dataWidth-1:0] e;
    logic [dataWidth-1:0] h;
    logic [dataWidth-1:0] l;
    logic [dataWidth-1:0] a;
    logic [addrWidth-1:0] x16;
  } regBankT;

  typedef struct packed {
    logic                 we;
    regSelT               sel;
    logic [dataWidth-1:0] data;
  } regWriteT;

  typedef struct packed {
    logic runFlow;  // Micro-op executes this cycle
    logic endFlow;
    uopT  uop;
  } seqCtrlT;

  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] wrData;
    logic                 writeEnable;
  } memReqT;

  // Byte read by selector, zero for the 16-bit and empty selections
  function automatic logic [dataWidth-1:0] readReg(input regBankT regs, input regSelT sel);
    case (sel)
      selB:         return regs.b;
      selC:         return regs.c;
      selD:         return regs.d;
      selE:         return regs.e;
      selH:         return regs.h;
      selL:         return regs.l;
      selMem, selA: return regs.a;
      selX16L:      return regs.x16[7:0];
      selX16H:      return regs.x16[15:8];
      default:      return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: source/microcodeRom.sv
`timescale 1ns/1ps
`default_nettype none

module microcodeRom
(
  input  wire  [gbCorePkg::flowIdxWidth-1:0] flowAddr,
  input  wire  [gbCorePkg::dataWidth-1:0]    fetchedOp,
  output gbCorePkg::uopT                     uop,
  output logic [gbCorePkg::flowIdxWidth-1:0] flowIdx
);

  gbCorePkg::opcodeT op;

  assign op = fetchedOp;

  // --------------------------------------------------------------------------
  // Micro-operation table
  always_comb
  begin
    case (flowAddr)
      // No-op and single Exec
      6'd0:  uop = '{gbCorePkg::cmdNop, gbCorePkg::eofAlways, 1'b1, gbCorePkg::selNone};
      6'd1:  uop = '{gbCorePkg::cmdExec, gbCorePkg::eofAlways, 1'b1, gbCorePkg::selNone};
      // LD r,n
      6'd2:  uop = '{gbCorePkg::cmdNop, gbCorePkg::eofNever, 1'b1, gbCorePkg::selNone};
      6'd3:  uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16L};
      6'd4:  uop = '{gbCorePkg::cmdExec, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selNone};
      // LD (nn),A
      6'd5:  uop = '{gbCorePkg::cmdNop, gbCorePkg::eofNever, 1'b1, gbCorePkg::selNone};
      6'd6:  uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16L};
      6'd7:  uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16H};
      6'd8:  uop = '{gbCorePkg::cmdSetAddr, gbCorePkg::eofNever, 1'b0, gbCorePkg::selX16};
      6'd9:  uop = '{gbCorePkg::cmdMemWrite, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selA};
      // JP nn
      6'd10: uop = '{gbCorePkg::cmdNop, gbCorePkg::eofNever, 1'b1, gbCorePkg::selNone};
      6'd11: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16L};
      6'd12: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16H};
      6'd13: uop = '{gbCorePkg::cmdSetPc, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selX16};
      // JP NZ,nn
      6'd14: uop = '{gbCorePkg::cmdNop, gbCorePkg::eofNever, 1'b1, gbCorePkg::selNone};
      6'd15: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16L};
      6'd16: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofIfZ, 1'b1, gbCorePkg::selX16H};
      6'd17: uop = '{gbCorePkg::cmdSetPc, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selX16};
      // JP Z,nn
      6'd18: uop = '{gbCorePkg::cmdNop, gbCorePkg::eofNever, 1'b1, gbCorePkg::selNone};
      6'd19: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16L};
      6'd20: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofIfNz, 1'b1, gbCorePkg::selX16H};
      6'd21: uop = '{gbCorePkg::cmdSetPc, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selX16};
      // JP NC,nn
      6'd22: uop = '{gbCorePkg::cmdNop, gbCorePkg::eofNever, 1'b1, gbCorePkg::selNone};
      6'd23: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16L};
      6'd24: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofIfC, 1'b1, gbCorePkg::selX16H};
      6'd25: uop = '{gbCorePkg::cmdSetPc, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selX16};
      // JP C,nn
      6'd26: uop = '{gbCorePkg::cmdNop, gbCorePkg::eofNever, 1'b1, gbCorePkg::selNone};
      6'd27: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofNever, 1'b1, gbCorePkg::selX16L};
      6'd28: uop = '{gbCorePkg::cmdStoreRead, gbCorePkg::eofIfNc, 1'b1, gbCorePkg::selX16H};
      6'd29: uop = '{gbCorePkg::cmdSetPc, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selX16};
      default: uop = '{gbCorePkg::cmdNop, gbCorePkg::eofAlways, 1'b0, gbCorePkg::selNone};
    endcase
  end

  // --------------------------------------------------------------------------
  // Opcode to flow start
  always_comb
  begin
    case (fetchedOp)
      gbCorePkg::ldA16: flowIdx = 6'd5;
      gbCorePkg::jpNn:  flowIdx = 6'd10;
      gbCorePkg::jpNz:  flowIdx = 6'd14;
      gbCorePkg::jpZ:   flowIdx = 6'd18;
      gbCorePkg::jpNc:  flowIdx = 6'd22;
      gbCorePkg::jpC:   flowIdx = 6'd26;
      default:
      begin
        flowIdx = 6'd0;  // Unknown means no-op
        if (op.ldView.group == 2'b01)
          flowIdx = 6'd1;
        else if (op.aluView.group == 2'b10 && op.aluView.aluOp inside
                 {gbCorePkg::aluAdd, gbCorePkg::aluSub, gbCorePkg::aluAnd,
                  gbCorePkg::aluXor, gbCorePkg::aluOr})
          flowIdx = 6'd1;
        else if (op.ldView.group == 2'b00 && op.ldView.src == 3'b110)
          flowIdx = 6'd2;  // LD r,n
        else if ((fetchedOp & 8'hc7) == gbCorePkg::opIncBase ||
                 (fetchedOp & 8'hc7) == gbCorePkg::opDecBase)
          flowIdx = 6'd1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer
(
  input  wire                            iClock,
  input  wire                            rstN,
  input  wire [gbCorePkg::dataWidth-1:0] memData,
  input  wire gbCorePkg::flagsT          flags,
  output gbCorePkg::seqCtrlT             ctrl,
  output gbCorePkg::opcodeT              opcode
);

  typedef enum logic [1:0] {
    stAfterReset, stStartFlow, stRunFlow, stEndFlow
  } stateT;

  stateT                             state;
  stateT                             nextState;
  logic [gbCorePkg::flowIdxWidth-1:0] uPc;
  logic [gbCorePkg::flowIdxWidth-1:0] flowIdx;
  gbCorePkg::uopT                     uop;
  logic                               eof;

  microcodeRom rom0
  (
    .flowAddr  (uPc),
    .fetchedOp (memData),
    .uop       (uop),
    .flowIdx   (flowIdx)
  );

  // End of flow against the current flags
  always_comb
  begin
    case (uop.eofCond)
      gbCorePkg::eofNever:  eof = 1'b0;
      gbCorePkg::eofIfC:    eof = flags.c;
      gbCorePkg::eofIfNc:   eof = ~flags.c;
      gbCorePkg::eofIfZ:    eof = flags.z;
      gbCorePkg::eofIfNz:   eof = ~flags.z;
      default:              eof = 1'b1;
    endcase
  end

  always_comb
  begin
    case (state)
      stAfterReset: nextState = stStartFlow;
      stStartFlow:  nextState = stRunFlow;
      stRunFlow:    nextState = eof ? stEndFlow : stRunFlow;
      default:      nextState = stStartFlow;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      state <= stAfterReset;
      uPc   <= '0;
    end
    else
    begin
      state <= nextState;
      if (state == stStartFlow)
        uPc <= flowIdx;
      else if (state == stRunFlow)
        uPc <= uPc + 1'b1;
    end
  end

  // Opcode seen at PC during StartFlow
  always_ff @(posedge iClock)
  begin
    if (state == stStartFlow)
      opcode <= memData;
  end

  assign ctrl = '{runFlow: (state == stRunFlow), endFlow: (state == stEndFlow), uop: uop};

endmodule

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
(
  input  wire                    iClock,
  input  wire                    rstN,
  input  wire gbCorePkg::regWriteT regWrite,
  output gbCorePkg::regBankT     regs
);

  always_ff @(posedge iClock)
  begin
    if (!rstN)
      regs <= '0;
    else if (regWrite.we)
    begin
      case (regWrite.sel)
        gbCorePkg::selB:    regs.b <= regWrite.data;
        gbCorePkg::selC:    regs.c <= regWrite.data;
        gbCorePkg::selD:    regs.d <= regWrite.data;
        gbCorePkg::selE:    regs.e <= regWrite.data;
        gbCorePkg::selH:    regs.h <= regWrite.data;
        gbCorePkg::selL:    regs.l <= regWrite.data;
        gbCorePkg::selMem,
        gbCorePkg::selA:    regs.a <= regWrite.data;  // (HL) slot folds onto A
        gbCorePkg::selX16L: regs.x16[7:0] <= regWrite.data;
        gbCorePkg::selX16H: regs.x16[15:8] <= regWrite.data;
        default:
        begin
          // X16 as a whole, PC and None take no byte write
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit
(
  input  wire                            iClock,
  input  wire                            rstN,
  input  wire gbCorePkg::seqCtrlT        ctrl,
  input  wire gbCorePkg::opcodeT         opcode,
  input  wire [gbCorePkg::dataWidth-1:0] memData,
  input  wire gbCorePkg::regBankT        regs,
  output gbCorePkg::regWriteT            regWrite,
  output gbCorePkg::flagsT               flags
);

  gbCorePkg::regSelT               dstSel;
  logic [gbCorePkg::dataWidth-1:0] srcVal;
  logic [gbCorePkg::dataWidth-1:0] dstVal;
  logic [gbCorePkg::dataWidth-1:0] incDecVal;
  logic [gbCorePkg::dataWidth-1:0] aluResult;
  logic                            aluCarry;
  logic                            flagsWe;
  gbCorePkg::flagsT                flagsNext;

  assign dstSel    = gbCorePkg::regSelT'({1'b0, opcode.ldView.dst});
  assign srcVal    = gbCorePkg::readReg(regs, gbCorePkg::regSelT'({1'b0, opcode.ldView.src}));
  assign dstVal    = gbCorePkg::readReg(regs, dstSel);
  assign incDecVal = opcode.ldView.src[0] ? dstVal - 8'd1 : dstVal + 8'd1;  // DEC : INC

  // ALU on A, carry is the borrow for SUB
  always_comb
  begin
    case (opcode.aluView.aluOp)
      gbCorePkg::aluAdd: {aluCarry, aluResult} = {1'b0, regs.a} + {1'b0, srcVal};
      gbCorePkg::aluSub: {aluCarry, aluResult} = {1'b0, regs.a} - {1'b0, srcVal};
      gbCorePkg::aluAnd: {aluCarry, aluResult} = {1'b0, regs.a & srcVal};
      gbCorePkg::aluXor: {aluCarry, aluResult} = {1'b0, regs.a ^ srcVal};
      gbCorePkg::aluOr:  {aluCarry, aluResult} = {1'b0, regs.a | srcVal};
      default:           {aluCarry, aluResult} = {flags.c, regs.a};
    endcase
  end

  // --------------------------------------------------------------------------
  // Register write and flag update
  always_comb
  begin
    regWrite  = '{we: 1'b0, sel: gbCorePkg::selNone, data: '0};
    flagsWe   = 1'b0;
    flagsNext = flags;
    if (ctrl.runFlow)
    begin
      case (ctrl.uop.cmd)
        gbCorePkg::cmdStoreRead:
          regWrite = '{we: 1'b1, sel: ctrl.uop.operand, data: memData};
        gbCorePkg::cmdExec:
        begin
          case (opcode.ldView.group)
            2'b01: regWrite = '{we: 1'b1, sel: dstSel, data: srcVal};  // LD r,r'
            2'b10:
            begin
              regWrite  = '{we: 1'b1, sel: gbCorePkg::selA, data: aluResult};
              flagsWe   = 1'b1;
              flagsNext = '{z: (aluResult == '0), c: aluCarry};
            end
            2'b00:
            begin
              if (opcode.ldView.src == 3'b110)
                regWrite = '{we: 1'b1, sel: dstSel, data: regs.x16[7:0]};  // LD r,n
              else
              begin
                regWrite    = '{we: 1'b1, sel: dstSel, data: incDecVal};
                flagsWe     = 1'b1;
                flagsNext.z = (incDecVal == '0);  // C kept
              end
            end
            default:
            begin
            end
          endcase
        end
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (!rstN)
      flags <= gbCorePkg::resetFlags;
    else if (flagsWe)
      flags <= flagsNext;
  end

endmodule

`default_nettype wire

// File: source/memoryPort.sv
`timescale 1ns/1ps
`default_nettype none

module memoryPort
(
  input  wire                     iClock,
  input  wire                     rstN,
  input  wire gbCorePkg::seqCtrlT ctrl,
  input  wire gbCorePkg::regBankT regs,
  output gbCorePkg::memReqT       memReq
);

  logic [gbCorePkg::addrWidth-1:0] pc;
  gbCorePkg::regSelT               addrSel;
  logic [gbCorePkg::addrWidth-1:0] busAddr;
  logic                            doWrite;

  // --------------------------------------------------------------------------
  // Program counter
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      pc <= gbCorePkg::resetPc;
    else if (ctrl.runFlow && ctrl.uop.cmd == gbCorePkg::cmdSetPc)
      pc <= regs.x16;  // Jump target wins over incPc
    else if (ctrl.runFlow && ctrl.uop.incPc)
      pc <= pc + 1'b1;
  end

  // Address select returns to PC once the instruction is done
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      addrSel <= gbCorePkg::selPc;
    else if (ctrl.endFlow)
      addrSel <= gbCorePkg::selPc;
    else if (ctrl.runFlow && ctrl.uop.cmd == gbCorePkg::cmdSetAddr)
      addrSel <= ctrl.uop.operand;
  end

  always_comb
  begin
    case (addrSel)
      gbCorePkg::selX16: busAddr = regs.x16;
      default:           busAddr = pc;
    endcase
  end

  assign doWrite = ctrl.runFlow && (ctrl.uop.cmd == gbCorePkg::cmdMemWrite);

  assign memReq = '{
    addr:        busAddr,
    wrData:      gbCorePkg::readReg(regs, ctrl.uop.operand),
    writeEnable: doWrite
  };

endmodule

`default_nettype wire

// File: source/gbCore.sv
`timescale 1ns/1ps
`default_nettype none

module gbCore
(
  input  wire                            iClock,
  input  wire                            rstN,
  input  wire [gbCorePkg::dataWidth-1:0] memData,
  output gbCorePkg::memReqT              memReq
);

  gbCorePkg::seqCtrlT  ctrl;
  gbCorePkg::opcodeT   opcode;
  gbCorePkg::regWriteT regWrite;
  gbCorePkg::flagsT    flags;
  gbCorePkg::regBankT  regs;

  sequencer seq0
  (
    .iClock  (iClock),
    .rstN    (rstN),
    .memData (memData),
    .flags   (flags),
    .ctrl    (ctrl),
    .opcode  (opcode)
  );

  registerFile regFile0
  (
    .iClock   (iClock),
    .rstN     (rstN),
    .regWrite (regWrite),
    .regs     (regs)
  );

  executeUnit exec0
  (
    .iClock   (iClock),
    .rstN     (rstN),
    .ctrl     (ctrl),
    .opcode   (opcode),
    .memData  (memData),
    .regs     (regs),
    .regWrite (regWrite),
    .flags    (flags)
  );

  memoryPort memPort0
  (
    .iClock (iClock),
    .rstN   (rstN),
    .ctrl   (ctrl),
    .regs   (regs),
    .memReq (memReq)
  );

endmodule

`default_nettype wire

// File: sim/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic nextRandomBit(output logic b);
  lfsrState = lfsrNext(lfsrState);
  b = lfsrState[0];
endtask

task automatic randomByte(output logic [7:0] v);
  logic b;
  v = '0;
  for (int k = 0; k < 8; k++)
  begin
    nextRandomBit(b);
    v = {v[6:0], b};
  end
endtask

task automatic randomReg(output logic [2:0] r);
  logic b;
  r = '0;
  for (int k = 0; k < 3; k++)
  begin
    nextRandomBit(b);
    r = {r[1:0], b};
  end
  if (r == 3'd6)
    r = 3'd7;  // A instead of the (HL) slot
endtask

task automatic putByte(input logic [7:0] b);
  image[buildPc] = b;
  buildPc = buildPc + 16'd1;
endtask

// ----------------------------------------------------------------------------
// Instruction emitters keep the register and flag model in step
task automatic ldImm(input logic [2:0] r, input logic [7:0] n);
  putByte({2'b00, r, 3'b110});
  putByte(n);
  regModel[r] = n;
  instrCount++;
endtask

task automatic ldReg(input logic [2:0] dst, input logic [2:0] src);
  putByte({2'b01, dst, src});
  regModel[dst] = regModel[src];
  instrCount++;
endtask

task automatic aluOp(input logic [2:0] op, input logic [2:0] src);
  logic [8:0] wide;
  putByte({2'b10, op, src});
  case (op)
    3'b000:  wide = {1'b0, regModel[7]} + {1'b0, regModel[src]};  // Carry out
    3'b010:  wide = {1'b0, regModel[7]} - {1'b0, regModel[src]};  // Borrow
    3'b100:  wide = {1'b0, regModel[7] & regModel[src]};
    3'b101:  wide = {1'b0, regModel[7] ^ regModel[src]};
    default: wide = {1'b0, regModel[7] | regModel[src]};
  endcase
  regModel[7] = wide[7:0];
  zModel = (wide[7:0] == 8'h00);
  cModel = wide[8];
  instrCount++;
endtask

task automatic incDec(input logic [2:0] r, input logic dec);
  putByte({2'b00, r, 2'b10, dec});
  regModel[r] = dec ? regModel[r] - 8'd1 : regModel[r] + 8'd1;
  zModel = (regModel[r] == 8'h00);  // C left alone
  instrCount++;
endtask

task automatic jump(input logic [7:0] opc, input logic [15:0] target);
  putByte(opc);
  putByte(target[7:0]);
  putByte(target[15:8]);
  instrCount++;
endtask

task automatic noOp(input logic [7:0] opc);
  putByte(opc);
  instrCount++;
endtask

// LD (nn),A to the next data address
task automatic storeFresh(input logic expected);
  putByte(gbCorePkg::ldA16);
  putByte(dataAddr[7:0]);
  putByte(dataAddr[15:8]);
  instrCount++;
  if (expected)
  begin
    expAddr[expCount[6:0]] = dataAddr;
    expData[expCount[6:0]] = regModel[7];
    expCount++;
  end
  dataAddr = dataAddr + 16'd1;
endtask

// JP cc around a fall-through store with both paths meeting at join
task automatic branchCheck(input logic [1:0] cc);
  logic [7:0]  opc;
  logic        taken;
  logic [15:0] target;
  case (cc)
    2'd0:    opc = gbCorePkg::jpNz;
    2'd1:    opc = gbCorePkg::jpZ;
    2'd2:    opc = gbCorePkg::jpNc;
    default: opc = gbCorePkg::jpC;
  endcase
  case (cc)
    2'd0:    taken = !zModel;
    2'd1:    taken = zModel;
    2'd2:    taken = !cModel;
    default: taken = cModel;
  endcase
  target = buildPc + 16'd11;  // JP cc, LD A,n, LD (nn),A, JP
  jump(opc, target);
  ldImm(3'd7, 8'h5a);
  storeFresh(!taken);
  jump(gbCorePkg::jpNn, target + 16'd5);
  ldImm(3'd7, 8'ha5);
  storeFresh(taken);
endtask

task automatic aluCase(input logic [2:0] op, input logic [7:0] a, input logic [7:0] b,
                       input logic [2:0] src, input logic [1:0] cc);
  ldImm(3'd7, a);
  ldImm(src, b);
  aluOp(op, src);
  storeFresh(1'b1);
  branchCheck(cc);
endtask

function automatic logic [2:0] aluCodeFor(input int idx);
  case (idx % 5)
    0:       return 3'b000;  // ADD
    1:       return 3'b010;  // SUB
    2:       return 3'b100;  // AND
    3:       return 3'b101;  // XOR
    default: return 3'b110;  // OR
  endcase
endfunction

// ----------------------------------------------------------------------------
task automatic buildProgram();
  logic [7:0] n;
  logic [7:0] m;
  logic [2:0] r;
  lfsrState  = 32'hc245_e657;
  buildPc    = gbCorePkg::resetPc;
  dataAddr   = 16'hc000;
  zModel     = gbCorePkg::resetFlags.z;
  cModel     = gbCorePkg::resetFlags.c;
  expCount   = 0;
  instrCount = 0;
  for (int i = 0; i < 65536; i++)
    image[i[15:0]] = 8'h00;
  for (int i = 0; i < 8; i++)
    regModel[i[2:0]] = 8'h00;

  // Immediate passed along B, C, D, E, H, L, A
  randomByte(n);
  ldImm(3'd0, n);
  for (int k = 1; k < 6; k++)
    ldReg(k[2:0], k[2:0] - 3'd1);
  ldReg(3'd7, 3'd5);
  storeFresh(1'b1);
  for (int k = 0; k < 7; k++)
  begin
    r = (k == 6) ? 3'd7 : k[2:0];
    randomByte(n);
    ldImm(r, n);
    ldReg(3'd7, r);
    storeFresh(1'b1);
  end

  // Directed flag corners before random operands
  aluCase(3'b000, 8'hff, 8'h01, 3'd0, 2'd1);
  aluCase(3'b010, 8'h37, 8'h37, 3'd1, 2'd0);
  aluCase(3'b010, 8'h10, 8'h20, 3'd2, 2'd3);
  aluCase(3'b100, 8'hf0, 8'h0f, 3'd3, 2'd2);
  aluCase(3'b101, 8'h5a, 8'h5a, 3'd4, 2'd1);
  aluCase(3'b110, 8'h00, 8'h00, 3'd5, 2'd0);
  for (int k = 0; k < 20; k++)
  begin
    randomByte(n);
    randomByte(m);
    randomReg(r);
    aluCase(aluCodeFor(k), n, m, r, k[1:0]);
  end

  // INC and DEC with C set beforehand and the first two wrapping to zero
  aluCase(3'b000, 8'hff, 8'h02, 3'd1, 2'd3);
  for (int k = 0; k < 8; k++)
  begin
    randomByte(n);
    randomReg(r);
    if (k < 2)
      n = (k == 0) ? 8'hff : 8'h01;
    ldImm(r, n);
    incDec(r, k[0]);
    ldReg(3'd7, r);
    storeFresh(1'b1);
    branchCheck(k[1:0]);
  end

  // JP nn over a store and two no-ops
  randomByte(n);
  ldImm(3'd7, n);
  jump(gbCorePkg::jpNn, buildPc + 16'd6);
  storeFresh(1'b0);
  storeFresh(1'b1);
  noOp(8'hd3);
  noOp(8'h00);
  storeFresh(1'b1);
  jump(gbCorePkg::jpNn, buildPc);  // Spin here
endtask

`endif

// File: sim/tbGbCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbGbCore;

  localparam int maxWrites   = 128;
  localparam int drainCycles = 200;

  logic              iClock = 1'b0;
  logic              rstN;
  logic [7:0]        memData;
  gbCorePkg::memReqT memReq;

  logic [7:0]  mem   [0:65535];
  logic [7:0]  image [0:65535];  // Program as built
  logic [15:0] expAddr [0:maxWrites-1];
  logic [7:0]  expData [0:maxWrites-1];
  int          expCount;
  int          writeCount;
  logic [6:0]  nextIdx;

  // Builder state and reference model
  logic [31:0] lfsrState;
  logic [15:0] buildPc;
  logic [15:0] dataAddr;
  logic [7:0]  regModel [0:7];  // Indexed by register field
  logic        zModel;
  logic        cModel;
  int          instrCount;
  logic        programReady = 1'b0;

  int wrongWrites = 0;
  int extraWrites = 0;
  int quietErrors = 0;
  int startErrors = 0;

  `include "tbProgram.svh"

  gbCore dut0
  (
    .iClock  (iClock),
    .rstN    (rstN),
    .memData (memData),
    .memReq  (memReq)
  );

  always #5 iClock = ~iClock;

  // --------------------------------------------------------------------------
  // Memory model loads the image while in reset
  assign memData = mem[memReq.addr];
  assign nextIdx = writeCount[6:0];

  always @(posedge iClock)
  begin
    if (!rstN)
      mem = image;
    else if (memReq.writeEnable)
      mem[memReq.addr] = memReq.wrData;
  end

  always @(posedge iClock)
  begin
    if (!rstN)
      writeCount <= 0;
    else if (memReq.writeEnable)
      writeCount <= writeCount + 1;
  end

  // --------------------------------------------------------------------------
  assert property (@(posedge iClock) !rstN |-> !memReq.writeEnable)
    else
    begin
      quietErrors++;
      $display("Write enable was high during reset at %0t", $time);
    end

  assert property (@(posedge iClock) $rose(rstN) |-> memReq.addr == gbCorePkg::resetPc)
    else
    begin
      startErrors++;
      $display("[FAIL] %0t: first bus address %h, expected %h", $time,
               $sampled(memReq.addr), gbCorePkg::resetPc);
    end

  assert property (@(posedge iClock) disable iff (!rstN)
      memReq.writeEnable |-> writeCount < expCount)
    else
    begin
      extraWrites++;
      $display("Unexpected write of %h to %h at %0t, no write was left to come",
               $sampled(memReq.wrData), $sampled(memReq.addr), $time);
    end

  assert property (@(posedge iClock) disable iff (!rstN)
      memReq.writeEnable && writeCount < expCount
      |-> memReq.addr == expAddr[nextIdx] && memReq.wrData == expData[nextIdx])
    else
    begin
      wrongWrites++;
      $display("[FAIL] %0t: write %0d put %h at %h, expected %h at %h", $time,
               $sampled(writeCount), $sampled(memReq.wrData), $sampled(memReq.addr),
               expData[$sampled(nextIdx)], expAddr[$sampled(nextIdx)]);
    end

  // Watchdog allows 60 cycles per instruction plus the drain
  initial
  begin
    wait (programReady);
    #((instrCount * 60 + drainCycles + 10) * 10);
    $display("Timeout: the expected writes did not all appear in time");
    $display("Something failed");
    $finish;
  end

  initial
  begin
    rstN = 1'b0;
    buildProgram();
    programReady = 1'b1;
    repeat (2) @(posedge iClock);
    #1 rstN = 1'b1;
    wait (writeCount >= expCount);
    repeat (drainCycles) @(posedge iClock);  // Nothing more may be written
    $display("Errors: %0d wrong writes, %0d unexpected writes, %0d reset faults",
             wrongWrites, extraWrites, quietErrors + startErrors);
    if (wrongWrites + extraWrites + quietErrors + startErrors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
source/gbCorePkg.sv
source/microcodeRom.sv
source/sequencer.sv
source/registerFile.sv
source/executeUnit.sv
source/memoryPort.sv
source/gbCore.sv
sim/tbGbCore.sv

// File: Makefile
# Verilator build and run of the gbCore testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tbGbCore
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASSTEXT  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASSTEXT)" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
